// ==== rtl/fifo_pkg.sv ====
// Shared widths and vector types for the same-clock FIFO.
// ADDR_W must be 2 or more. DEPTH is always a power of two, so the
// pointers wrap on their own. Change the widths here only.

package fifo_pkg;

    localparam int ADDR_W = 4;            // memory address width.
    localparam int DATA_W = 16;           // stored word width.
    localparam int DEPTH  = 1 << ADDR_W;  // words in the array.
    localparam int FILL_W = ADDR_W + 1;   // counts 0..DEPTH inclusive.

    // one stored word, as written and as presented on dout.
    typedef logic [DATA_W-1:0] fifo_data_t;

    // read or write address into the array.
    typedef logic [ADDR_W-1:0] fifo_addr_t;

    // words held in the array, excluding latch and output register.
    typedef logic [FILL_W-1:0] fifo_fill_t;

    // fill value at which the array has no free slot.
    localparam fifo_fill_t FILL_FULL = fifo_fill_t'(DEPTH);

    // unit steps, so pointer and counter arithmetic keeps its width.
    localparam fifo_addr_t ADDR_ONE = fifo_addr_t'(1);
    localparam fifo_fill_t FILL_ONE = fifo_fill_t'(1);

endpackage

// ==== rtl/bram_sdp_reg.sv ====
// Behavioral simple dual-port block RAM, one clock.
// Read goes through a latch loaded on re, then an output register loaded on regen.
// Read and write of the same address in one cycle returns the old word.
// No reset anywhere, as in the real primitive.
`timescale 1ns/1ns

module bram_sdp_reg (
    input  logic                 clk,
    input  logic                 we,      // write enable.
    input  fifo_pkg::fifo_addr_t wa,      // write address.
    input  fifo_pkg::fifo_data_t wd,      // write data.
    input  logic                 re,      // load read latch.
    input  fifo_pkg::fifo_addr_t ra,      // read address.
    input  logic                 regen,   // load output register.
    output fifo_pkg::fifo_data_t rd_data  // output register.
);

    import fifo_pkg::*;

    fifo_data_t mem [DEPTH];  // storage array.
    fifo_data_t ram_q;        // read latch.
    fifo_data_t out_q;        // output register.

    // write port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
    end

    // read latch, old data on address collision.
    always_ff @(posedge clk) begin
        if (re) begin
            ram_q <= mem[ra];
        end
    end

    // output register, holds while regen is low.
    always_ff @(posedge clk) begin
        if (regen) begin
            out_q <= ram_q;
        end
    end

    assign rd_data = out_q;

endmodule

// ==== rtl/fifo_ctrl.sv ====
// Control for a BRAM FIFO whose read path has a latch and an output register.
// fill counts words in the array only. Total capacity is DEPTH+2 words.
// A write into a full array is not refused. over flags it, and data is then undefined.
// rd is masked by nempty inside, and a masked rd only raises under.
`timescale 1ns/1ns

module fifo_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr,        // write strobe, also goes straight to memory.
    input  logic                 rd,        // consume current dout.
    output logic                 nempty,    // dout holds a valid word.
    output fifo_pkg::fifo_fill_t fill,      // array level, write side.
    output fifo_pkg::fifo_addr_t mem_wa,    // memory write address.
    output fifo_pkg::fifo_addr_t mem_ra,    // memory read address.
    output logic                 mem_re,    // load ram latch.
    output logic                 mem_regen, // load output register.
    output logic                 over,      // write into full array, one cycle.
    output logic                 under      // read while empty, one cycle.
);

    import fifo_pkg::*;

    fifo_fill_t fill_q;     // words waiting in the array.
    logic       ramo_full;  // ram latch holds a word.
    logic       rreg_full;  // output register holds a word.
    logic       array_any;  // array not empty.
    logic       rd_take;    // rd that really consumes a word.

    assign array_any = |fill_q;
    assign rd_take   = rd && rreg_full;  // masked by nempty.

    // latch may load if it is free, or will be freed this cycle.
    // a free output register means the latch moves on anyway.
    assign mem_re    = array_any && (!ramo_full || !rreg_full || rd_take);

    // output register takes the latch if free or being consumed.
    assign mem_regen = ramo_full && (!rreg_full || rd_take);

    assign nempty = rreg_full;
    assign fill   = fill_q;

    // write pointer.
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wa <= '0;
        end else if (wr) begin
            mem_wa <= mem_wa + ADDR_ONE;  // wraps at DEPTH.
        end
    end

    // read pointer, steps with every latch load.
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ra <= '0;
        end else if (mem_re) begin
            mem_ra <= mem_ra + ADDR_ONE;
        end
    end

    // array level, up on write alone, down on read alone.
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_q <= '0;
        end else begin
            case ({wr, mem_re})
                2'b10:   fill_q <= fill_q + FILL_ONE;
                2'b01:   fill_q <= fill_q - FILL_ONE;
                default: fill_q <= fill_q;  // both or neither.
            endcase
        end
    end

    // latch occupancy, set on load, cleared when passed on.
    always_ff @(posedge clk) begin
        if (rst) begin
            ramo_full <= 1'b0;
        end else if (mem_re ^ mem_regen) begin
            ramo_full <= mem_re;
        end
    end

    // output register occupancy, this is nempty.
    always_ff @(posedge clk) begin
        if (rst) begin
            rreg_full <= 1'b0;
        end else if (mem_regen ^ rd_take) begin
            rreg_full <= mem_regen;  // refill wins over consume.
        end
    end

    // error pulses, registered.
    always_ff @(posedge clk) begin
        if (rst) begin
            over  <= 1'b0;
            under <= 1'b0;
        end else begin
            over  <= wr && (fill_q == FILL_FULL);  // latch and reg full too by then.
            under <= rd && !rreg_full;
        end
    end

endmodule

// ==== rtl/sameclock_fifo.sv ====
// First-word-fall-through FIFO on a registered-output block RAM, one clock.
// dout is valid while nempty is high. rd takes that word at the next edge.
// First word appears on the second edge after the edge that samples wr.
// fill shows the array only. Up to two more words sit in the read path.
`timescale 1ns/1ns

module sameclock_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr,      // write din this cycle.
    input  fifo_pkg::fifo_data_t din,
    input  logic                 rd,      // consume dout.
    output fifo_pkg::fifo_data_t dout,
    output logic                 nempty,  // dout valid.
    output fifo_pkg::fifo_fill_t fill,    // array level.
    output logic                 over,    // overflow pulse.
    output logic                 under    // underflow pulse.
);

    import fifo_pkg::*;

    fifo_addr_t mem_wa;     // write address.
    fifo_addr_t mem_ra;     // read address.
    logic       mem_re;     // latch load.
    logic       mem_regen;  // output reg load.

    // pointers, levels and read path occupancy.
    fifo_ctrl fifo_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .rd        (rd),
        .nempty    (nempty),
        .fill      (fill),
        .mem_wa    (mem_wa),
        .mem_ra    (mem_ra),
        .mem_re    (mem_re),
        .mem_regen (mem_regen),
        .over      (over),
        .under     (under)
    );

    // storage gets wr and din unmodified.
    bram_sdp_reg bram_sdp_reg_i (
        .clk     (clk),
        .we      (wr),
        .wa      (mem_wa),
        .wd      (din),
        .re      (mem_re),
        .ra      (mem_ra),
        .regen   (mem_regen),
        .rd_data (dout)
    );

endmodule

// ==== tests/fifo_tb.sv ====
// Testbench for the same-clock FIFO that steps one golden line per clock cycle.
// Expected outputs in a golden line are those seen during that cycle,
// before the line's own inputs take effect at the next edge.
// Run from the project root so the golden file path resolves.
`timescale 1ns/1ns

module fifo_tb;

    import fifo_pkg::*;

    localparam int    CLK_PERIOD    = 20;
    localparam int    DRIVE_DELAY   = 2;    // after rising edge.
    localparam int    SAMPLE_DELAY  = 8;    // mid cycle after the drive.
    localparam int    RESET_CYCLES  = 3;
    localparam int    MARGIN_CYCLES = 20;   // slack for the watchdog.
    localparam string GOLDEN_PATH   = "tests/fifo_golden.txt";

    // bits of the chk column.
    localparam int CHK_DOUT  = 1;  // dout against the file.
    localparam int CHK_MODEL = 2;  // random din with dout against queue model.
    localparam int CHK_FILL  = 4;  // fill against the file.

    logic       clk;
    logic       rst;
    logic       wr;
    fifo_data_t din;
    logic       rd;
    fifo_data_t dout;
    logic       nempty;
    fifo_fill_t fill;
    logic       over;
    logic       under;

    // golden lines with one entry per cycle.
    string      name_q[$];
    logic       wr_q[$];
    fifo_data_t din_q[$];
    logic       rd_q[$];
    fifo_data_t exp_dout_q[$];
    logic       exp_nempty_q[$];
    fifo_fill_t exp_fill_q[$];
    logic       exp_over_q[$];
    logic       exp_under_q[$];
    int         chk_q[$];

    fifo_data_t  model_q[$];       // random words still inside the FIFO.
    logic [31:0] rnd_state;
    int          n_lines = 0;
    int          cur_line;
    int          err_count;
    int          test_errs;        // mismatches in the running test.
    int          tests_run;
    int          tests_failed;

    sameclock_fifo sameclock_fifo_i (
        .clk    (clk),
        .rst    (rst),
        .wr     (wr),
        .din    (din),
        .rd     (rd),
        .dout   (dout),
        .nempty (nempty),
        .fill   (fill),
        .over   (over),
        .under  (under)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // 32-bit xorshift step.
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_data(input string test, input string what,
                              input fifo_data_t exp, input fifo_data_t act);
        if (act !== exp) begin
            $display("FAILED %s line %0d: %s expected %h, actual %h",
                     test, cur_line, what, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_fill(input string test, input fifo_fill_t exp, input fifo_fill_t act);
        if (act !== exp) begin
            $display("FAILED %s line %0d: fill expected %0d, actual %0d",
                     test, cur_line, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s line %0d: %s expected %b, actual %b",
                     test, cur_line, what, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    // reads all operations. count is -1 on a bad file.
    task automatic load_golden(output int count);
        int    fd;
        int    n;
        string line;
        string nm;
        int    v_wr;
        int    v_din;
        int    v_rd;
        int    v_dout;
        int    v_ne;
        int    v_fill;
        int    v_over;
        int    v_under;
        int    v_chk;
        count = -1;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            $display("cannot open golden file %s", GOLDEN_PATH);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r") begin
                continue;  // blank or comment.
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", nm, v_wr, v_din, v_rd,
                        v_dout, v_ne, v_fill, v_over, v_under, v_chk);
            if (n != 10) begin
                $display("golden file has a malformed line: %s", line);
                $fclose(fd);
                return;
            end
            name_q.push_back(nm);
            wr_q.push_back(v_wr[0]);
            din_q.push_back(fifo_data_t'(v_din));
            rd_q.push_back(v_rd[0]);
            exp_dout_q.push_back(fifo_data_t'(v_dout));
            exp_nempty_q.push_back(v_ne[0]);
            exp_fill_q.push_back(fifo_fill_t'(v_fill));
            exp_over_q.push_back(v_over[0]);
            exp_under_q.push_back(v_under[0]);
            chk_q.push_back(v_chk);
        end
        $fclose(fd);
        count = name_q.size();
    endtask

    // drives the inputs of one line with random data in model mode.
    task automatic drive_line(input int i);
        wr = wr_q[i];
        rd = rd_q[i];
        if ((chk_q[i] & CHK_MODEL) != 0 && wr_q[i]) begin
            rnd_state = xorshift32(rnd_state);
            din = fifo_data_t'(rnd_state);
            model_q.push_back(din);
        end else begin
            din = din_q[i];
        end
    endtask

    // outputs seen in this cycle.
    task automatic check_line(input int i);
        string t;
        t = name_q[i];
        check_flag(t, "nempty", exp_nempty_q[i], nempty);
        check_flag(t, "over", exp_over_q[i], over);
        check_flag(t, "under", exp_under_q[i], under);
        if ((chk_q[i] & CHK_FILL) != 0) begin
            check_fill(t, exp_fill_q[i], fill);
        end
        if ((chk_q[i] & CHK_DOUT) != 0) begin
            check_data(t, "dout", exp_dout_q[i], dout);
        end
        if ((chk_q[i] & CHK_MODEL) != 0 && exp_nempty_q[i]) begin
            if (model_q.size() == 0) begin
                $display("test %s line %0d: queue model is empty but a word is expected",
                         t, cur_line);
                err_count++;
                test_errs++;
            end else begin
                check_data(t, "dout", model_q[0], dout);
                if (rd_q[i]) begin
                    void'(model_q.pop_front());  // consumed at next edge.
                end
            end
        end
    endtask

    task automatic report_test(input string t);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: passed", t);
        end else begin
            $display("test %s: %0d mismatches", t, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    initial begin
        int count;
        rst          = 1'b1;
        wr           = 1'b0;
        din          = '0;
        rd           = 1'b0;
        rnd_state    = 32'h6551b8b8;
        err_count    = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_line     = 0;
        load_golden(count);
        if (count <= 0) begin
            $display("no operations could be read from the golden file");
            err_count++;
        end else begin
            n_lines = count;  // starts the watchdog.
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst = 1'b0;
            for (int i = 0; i < n_lines; i++) begin
                cur_line = i + 1;
                drive_line(i);
                #SAMPLE_DELAY;
                check_line(i);
                if (i == n_lines - 1 || name_q[i + 1] != name_q[i]) begin
                    report_test(name_q[i]);
                end
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the golden length.
    initial begin
        wait (n_lines > 0);
        #((n_lines + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the run did not end within %0d cycles",
                 n_lines + RESET_CYCLES + MARGIN_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tests/fifo_golden.txt ====
# name wr din rd dout nempty fill over under chk, all but name in hex, one line per cycle
# outputs as seen in the cycle; chk bits 1 dout, 2 random din with model dout, 4 fill

# state right after reset.
reset        0 0000 0 0000 0 00 0 0 4

# one write, nempty three lines later, then one read.
single_write 1 a5a5 0 0000 0 00 0 0 4
single_write 0 0000 0 0000 0 01 0 0 4
single_write 0 0000 0 0000 0 00 0 0 4
single_write 0 0000 0 a5a5 1 00 0 0 5
single_write 0 0000 1 a5a5 1 00 0 0 5
single_write 0 0000 0 0000 0 00 0 0 4

# read while empty, dout keeps the last word.
underflow    0 0000 1 a5a5 0 00 0 0 5
underflow    0 0000 0 a5a5 0 00 0 1 5
underflow    0 0000 0 a5a5 0 00 0 0 5

# six writes, then back-to-back reads.
burst        1 1111 0 0000 0 00 0 0 4
burst        1 2222 0 0000 0 01 0 0 4
burst        1 3333 0 0000 0 01 0 0 4
burst        1 4444 0 1111 1 01 0 0 5
burst        1 5555 0 1111 1 02 0 0 5
burst        1 6666 0 1111 1 03 0 0 5
burst        0 0000 1 1111 1 04 0 0 5
burst        0 0000 1 2222 1 03 0 0 5
burst        0 0000 1 3333 1 02 0 0 5
burst        0 0000 1 4444 1 01 0 0 5
burst        0 0000 1 5555 1 00 0 0 5
burst        0 0000 1 6666 1 00 0 0 5
burst        0 0000 0 0000 0 00 0 0 4

# preload four random words, stream ten with wr and rd together, drain.
stream       1 0000 0 0000 0 00 0 0 6
stream       1 0000 0 0000 0 01 0 0 6
stream       1 0000 0 0000 0 01 0 0 6
stream       1 0000 0 0000 1 01 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       1 0000 1 0000 1 02 0 0 6
stream       0 0000 1 0000 1 02 0 0 6
stream       0 0000 1 0000 1 01 0 0 6
stream       0 0000 1 0000 1 00 0 0 6
stream       0 0000 1 0000 1 00 0 0 6
stream       0 0000 0 0000 0 00 0 0 6

# eighteen writes fill array, latch and output register; the nineteenth overflows.
overflow     1 0101 0 0000 0 00 0 0 4
overflow     1 0102 0 0000 0 01 0 0 4
overflow     1 0103 0 0000 0 01 0 0 4
overflow     1 0104 0 0101 1 01 0 0 5
overflow     1 0105 0 0101 1 02 0 0 5
overflow     1 0106 0 0101 1 03 0 0 5
overflow     1 0107 0 0101 1 04 0 0 5
overflow     1 0108 0 0101 1 05 0 0 5
overflow     1 0109 0 0101 1 06 0 0 5
overflow     1 010a 0 0101 1 07 0 0 5
overflow     1 010b 0 0101 1 08 0 0 5
overflow     1 010c 0 0101 1 09 0 0 5
overflow     1 010d 0 0101 1 0a 0 0 5
overflow     1 010e 0 0101 1 0b 0 0 5
overflow     1 010f 0 0101 1 0c 0 0 5
overflow     1 0110 0 0101 1 0d 0 0 5
overflow     1 0111 0 0101 1 0e 0 0 5
overflow     1 0112 0 0101 1 0f 0 0 5
overflow     1 0113 0 0101 1 10 0 0 5
overflow     0 0000 0 0000 1 00 1 0 0
overflow     0 0000 0 0000 1 00 0 0 0

# drain after overflow, data undefined so flags only.
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 1 0000 1 00 0 0 0
drain        0 0000 0 0000 0 00 0 0 4

// ==== sim.f ====
rtl/fifo_pkg.sv
rtl/bram_sdp_reg.sv
rtl/fifo_ctrl.sv
rtl/sameclock_fifo.sv
tests/fifo_tb.sv

// ==== Bender.yml ====
package:
  name: sameclock_fifo

sources:
  # design, package first.
  - rtl/fifo_pkg.sv
  - rtl/bram_sdp_reg.sv
  - rtl/fifo_ctrl.sv
  - rtl/sameclock_fifo.sv

  # testbench, reads tests/fifo_golden.txt from the project root.
  - target: simulation
    files:
      - tests/fifo_tb.sv
